//--- lm_board.f
src/board_pkg.sv
src/mem_pkg.sv
src/mem_port_if.sv
src/dram_cmd_if.sv
src/reset_sequencer.sv
src/mem_arbiter.sv
src/dram_backend.sv
src/status_leds.sv
src/lm_board.sv
testbench/lm_board_sva.sv
testbench/tb_lm_board.sv

//--- testbench/tb_lm_board.sv
// directed tests; the led test waits for the dimmer half period, about 2^19 cycles of run time
`timescale 1ns/1ns
`default_nettype none

module tb_lm_board;
   import board_pkg::*;
   import mem_pkg::*;

   localparam int CALIB_WAIT = 32;                   // back-end calibration length
   localparam int DIM_HALF   = 2**(DIMMER_BITS-1);   // cycles until dimmed leds light
   localparam int WATCHDOG   = 2**20 + 20000;        // dimmer period plus test margin

   logic                  sysclk = 1'b0;
   logic                  rst;
   logic                  promdis;
   logic [BDST_W-1:0]     bdst;
   logic                  vga_req;
   logic [VRAM_AW-1:0]    vga_addr;
   logic [DATA_W-1:0]     vga_rdata;
   logic                  vga_ready;
   logic                  vga_done;
   logic                  sdram_req;
   logic                  sdram_write;
   logic [SDRAM_AW-1:0]   sdram_addr;
   logic [DATA_W-1:0]     sdram_wdata;
   logic [DATA_W-1:0]     sdram_rdata;
   logic                  sdram_ready;
   logic                  sdram_done;
   logic                  vram_req;
   logic                  vram_write;
   logic [VRAM_AW-1:0]    vram_addr;
   logic [DATA_W-1:0]     vram_wdata;
   logic [DATA_W-1:0]     vram_rdata;
   logic                  vram_ready;
   logic                  vram_done;
   logic                  machine_reset;
   logic                  boot;
   logic                  cpu_en;
   logic [15:0]           led;

   integer                seed = 27248;
   int                    err_cnt = 0;
   int                    cycle_cnt;               // edges since rst release
   logic [DATA_W-1:0]     model_mem [2**(STORE_AW+1)];

   lm_board i_lm_board (.*);

   always #4 sysclk = ~sysclk;  // 8 ns period

   always @(posedge sysclk) begin
      if (rst)
         cycle_cnt <= 0;
      else
         cycle_cnt <= cycle_cnt + 1;
   end

   initial begin
      repeat (WATCHDOG) @(posedge sysclk);
      report_hang("watchdog expired before the tests finished");
   end

   //////////////////////////////
   // reporting and port helpers
   //////////////////////////////
   task automatic halt_run();
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic report_mismatch(input string msg);
      err_cnt++;
      $display("FAIL at %0t ns: %s", $time, msg);
      halt_run();
   endtask

   task automatic report_hang(input string msg);
      $display("timeout: %s", msg);
      halt_run();
   endtask

   // port 0 vga, 1 sdram, 2 vram
   function automatic logic done_of(input int port);
      return (port == 0) ? vga_done : (port == 1) ? sdram_done : vram_done;
   endfunction

   function automatic logic ready_of(input int port);
      return (port == 0) ? vga_ready : (port == 1) ? sdram_ready : vram_ready;
   endfunction

   function automatic logic [DATA_W-1:0] rdata_of(input int port);
      return (port == 0) ? vga_rdata : (port == 1) ? sdram_rdata : vram_rdata;
   endfunction

   // region bit plus the kept low bits, so higher bits alias
   function automatic int model_index(input int port, input logic [SDRAM_AW-1:0] addr);
      logic region;
      region = (port == 1) ? 1'b0 : 1'b1;   // only sdram reaches main memory
      return {region, addr[STORE_AW-1:0]};
   endfunction

   task automatic drive_req(input int port, input logic wr, input logic [SDRAM_AW-1:0] addr,
                            input logic [DATA_W-1:0] wdata);
      case (port)
         0: begin
            vga_req  <= 1'b1;
            vga_addr <= addr[VRAM_AW-1:0];
         end
         1: begin
            sdram_req   <= 1'b1;
            sdram_write <= wr;
            sdram_addr  <= addr;
            sdram_wdata <= wdata;
         end
         default: begin
            vram_req   <= 1'b1;
            vram_write <= wr;
            vram_addr  <= addr[VRAM_AW-1:0];
            vram_wdata <= wdata;
         end
      endcase
   endtask

   task automatic clear_reqs();
      vga_req   <= 1'b0;
      sdram_req <= 1'b0;
      vram_req  <= 1'b0;
   endtask

   task automatic wait_ready(input int port);
      int n;
      n = 0;
      while (!ready_of(port)) begin
         @(negedge sysclk);
         n++;
         if (n > 100)
            report_hang($sformatf("port %0d never became ready", port));
      end
   endtask

   // one request, waits for done; called and returns at a falling edge
   task automatic access(input int port, input logic wr, input logic [SDRAM_AW-1:0] addr,
                         input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
      int n;
      wait_ready(port);
      @(posedge sysclk);
      drive_req(port, wr, addr, wdata);
      n = 0;
      do begin
         @(posedge sysclk);
         n++;
         if (n == 1)
            clear_reqs();
         @(negedge sysclk);
         if (n > 10)
            report_hang($sformatf("no done on port %0d", port));
      end while (!done_of(port));
      assert (n >= MEM_LATENCY + 1 && n <= 6)
         else report_mismatch($sformatf("port %0d latency %0d", port, n));
      rdata = rdata_of(port);
   endtask

   task automatic write_word(input int port, input logic [SDRAM_AW-1:0] addr,
                             input logic [DATA_W-1:0] data);
      logic [DATA_W-1:0] unused;
      access(port, 1'b1, addr, data, unused);
      model_mem[model_index(port, addr)] = data;
   endtask

   task automatic read_check(input int port, input logic [SDRAM_AW-1:0] addr);
      logic [DATA_W-1:0] got;
      int                idx;
      idx = model_index(port, addr);
      access(port, 1'b0, addr, '0, got);
      assert (got === model_mem[idx])
         else report_mismatch($sformatf("port %0d addr %h read %h expected %h",
                                        port, addr, got, model_mem[idx]));
   endtask

   //////////////////////////////
   // directed tests
   //////////////////////////////
   task automatic test_boot();
      int n;
      int boots;
      logic prev_en;
      repeat (9) @(posedge sysclk);
      @(negedge sysclk);
      assert (led[15:4] == '0 && !boot && !cpu_en && machine_reset)
         else report_mismatch("outputs not in reset state");
      assert (!vga_ready && !sdram_ready && !vram_ready)
         else report_mismatch("ready high during reset");
      @(posedge sysclk);
      rst <= 1'b0;
      n = 0;
      do begin
         @(posedge sysclk);
         n++;
         @(negedge sysclk);
         if (n > 200)
            report_hang("calibration never showed on led[0]");
      end while (!led[0]);
      // dram reset, calibration, then the sticky latch
      assert (n == DRAM_RESET_CYCLES + CALIB_WAIT + 1)
         else report_mismatch($sformatf("led[0] lit after %0d cycles", n));
      n = 0;
      boots = 0;
      do begin
         @(posedge sysclk);
         n++;
         @(negedge sysclk);
         boots += boot;
         if (n > 50)
            report_hang("machine_reset never fell");
      end while (machine_reset);
      assert (n == MACH_RESET_CYCLES && boot && !cpu_en)
         else report_mismatch($sformatf("machine_reset fell after %0d cycles", n));
      prev_en = cpu_en;
      repeat (6) begin
         @(negedge sysclk);
         boots += boot;
         assert (cpu_en == !prev_en)
            else report_mismatch("cpu_en not toggling");
         prev_en = cpu_en;
      end
      assert (boots == 1)
         else report_mismatch($sformatf("%0d boot pulses", boots));
   endtask

   task automatic test_main_rw();
      logic [SDRAM_AW-1:0]          addrs [16];
      logic [SDRAM_AW-STORE_AW-1:0] hi;
      logic [SDRAM_AW-1:0]          alias_addr;
      for (int i = 0; i < 16; i++) begin
         addrs[i] = $random(seed);
         write_word(1, addrs[i], $random(seed));
      end
      for (int i = 0; i < 16; i++)
         read_check(1, addrs[i]);
      // upper bits are not stored
      for (int i = 0; i < 4; i++) begin
         hi = $random(seed);
         hi[0] = 1'b1;
         alias_addr = addrs[i] ^ (SDRAM_AW'(hi) << STORE_AW);
         read_check(1, alias_addr);
         write_word(1, alias_addr, $random(seed));
         read_check(1, addrs[i]);
      end
   endtask

   task automatic test_regions();
      logic [SDRAM_AW-1:0] low;
      logic [DATA_W-1:0]   data;
      low  = SDRAM_AW'($random(seed) & 32'h3ff);
      data = $random(seed);
      write_word(1, low, data);
      write_word(2, low, ~data);   // same low address, video side
      read_check(1, low);
      read_check(0, low);
      read_check(2, low);
   endtask

   task automatic test_contention();
      logic [SDRAM_AW-1:0] a_main;
      logic [SDRAM_AW-1:0] a_vid;
      logic [SDRAM_AW-1:0] a_new;
      logic [DATA_W-1:0]   d_new;
      logic [DATA_W-1:0]   got [3];
      int                  ndone [3];
      int                  lat [3];
      a_main = $random(seed);
      a_vid  = SDRAM_AW'($random(seed) & 32'h7fff);
      a_new  = a_vid ^ 1;          // distinct stored word
      d_new  = $random(seed);
      write_word(1, a_main, $random(seed));
      write_word(2, a_vid, $random(seed));
      for (int p = 0; p < 3; p++) begin
         wait_ready(p);
         ndone[p] = 0;
         lat[p] = 0;
      end
      @(posedge sysclk);
      drive_req(0, 1'b0, a_vid, '0);
      drive_req(1, 1'b0, a_main, '0);
      drive_req(2, 1'b1, a_new, d_new);
      for (int n = 1; n <= 8; n++) begin
         @(posedge sysclk);
         if (n == 1)
            clear_reqs();
         @(negedge sysclk);
         for (int p = 0; p < 3; p++) begin
            if (done_of(p)) begin
               ndone[p]++;
               lat[p] = n;
               got[p] = rdata_of(p);
            end
         end
      end
      // one issue per cycle, vga first, then sdram, then vram
      for (int p = 0; p < 3; p++) begin
         assert (ndone[p] == 1 && lat[p] == MEM_LATENCY + 1 + p)
            else report_mismatch($sformatf("port %0d: %0d done, latency %0d",
                                           p, ndone[p], lat[p]));
      end
      assert (got[0] === model_mem[model_index(0, a_vid)])
         else report_mismatch($sformatf("vga read %h under contention", got[0]));
      assert (got[1] === model_mem[model_index(1, a_main)])
         else report_mismatch($sformatf("sdram read %h under contention", got[1]));
      model_mem[model_index(2, a_new)] = d_new;
      read_check(2, a_new);
      read_check(0, a_new);
   endtask

   // map as wired on the board
   function automatic logic [15:0] led_expect(input logic [2:0] rs, input logic [6:0] bd);
      logic [15:0] e;
      e       = '0;
      e[3:0]  = 4'b1101;   // running, boot seen, out of reset, calibrated
      e[4]    = rs[0];
      e[7]    = rs[1];
      e[10]   = rs[2];
      e[5]    = 1'b1;      // promdis seen
      e[13]   = 1'b1;      // boot seen
      e[6]    = bd[0];
      e[8]    = bd[1];
      e[9]    = bd[2];
      e[11]   = bd[3];
      e[12]   = bd[4];
      e[14]   = bd[5];
      e[15]   = bd[6];
      return e;
   endfunction

   task automatic test_leds();
      logic [BDST_W-1:0] bd;
      bd = $random(seed);
      @(posedge sysclk);
      bdst    <= bd;
      promdis <= 1'b1;
      @(posedge sysclk);
      promdis <= 1'b0;     // one pulse, the flag must hold
      while (cycle_cnt < DIM_HALF - 1)
         @(negedge sysclk);
      assert (led[15:4] == '0)
         else report_mismatch($sformatf("dimmed leds %h before dim_en", led[15:4]));
      while (cycle_cnt < DIM_HALF + 2)
         @(negedge sysclk);
      assert (led == led_expect(3'(RS_RUN), bd))
         else report_mismatch($sformatf("led %h expected %h", led, led_expect(3'(RS_RUN), bd)));
      @(posedge sysclk);
      bdst <= ~bd;
      repeat (2) @(negedge sysclk);
      assert (led == led_expect(3'(RS_RUN), ~bd))
         else report_mismatch($sformatf("led %h after bdst change", led));
   endtask

   initial begin
      rst         = 1'b1;
      promdis     = 1'b0;
      bdst        = '0;
      vga_req     = 1'b0;
      vga_addr    = '0;
      sdram_req   = 1'b0;
      sdram_write = 1'b0;
      sdram_addr  = '0;
      sdram_wdata = '0;
      vram_req    = 1'b0;
      vram_write  = 1'b0;
      vram_addr   = '0;
      vram_wdata  = '0;
      test_boot();
      test_main_rw();
      test_regions();
      test_contention();
      test_leds();
      if (err_cnt == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/lm_board_sva.sv
// bound into mem_arbiter; client index 0 vga, 1 sdram, 2 vram; inactive while rst is high
`timescale 1ns/1ns
`default_nettype none

module lm_board_sva (
   input  logic        sysclk,
   input  logic        rst,
   input  logic        calib_done,
   input  logic        issue,
   input  logic [2:0]  req,
   input  logic [2:0]  ready,
   input  logic [2:0]  done
);

   logic [2:0] outst; // accepted, waiting for done

   always_ff @(posedge sysclk) begin
      if (rst)
         outst <= '0;
      else
         outst <= (outst | (req & ready)) & ~done;
   end

   for (genvar i = 0; i < 3; i++) begin : g_client
      req_while_ready: assert property (@(posedge sysclk) disable iff (rst)
         req[i] |-> ready[i])
         else $error("client %0d pulsed req while ready was low", i);
      done_after_req: assert property (@(posedge sysclk) disable iff (rst)
         done[i] |-> outst[i])
         else $error("client %0d saw done without a request", i);
      done_in_time: assert property (@(posedge sysclk) disable iff (rst)
         (req[i] && ready[i]) |-> ##[1:6] done[i])
         else $error("client %0d got no done within 6 cycles", i);
   end

   // nothing accepted before the back end is calibrated
   ready_needs_calib: assert property (@(posedge sysclk) disable iff (rst)
      !calib_done |-> !issue)
      else $error("command issued before calib_done");

endmodule

bind mem_arbiter lm_board_sva i_lm_board_sva (
   .sysclk     (sysclk),
   .rst        (rst),
   .calib_done (cmd.calib_done),
   .issue      (cmd.issue),
   .req        (req_in),
   .ready      (ready),
   .done       (done)
);

`default_nettype wire

//--- src/lm_board.sv
// board shell without the core; vga port is read only, all logic on sysclk
`timescale 1ns/1ns
`default_nettype none

module lm_board (
   input  logic                          sysclk,
   input  logic                          rst,
   input  logic                          promdis,
   input  logic [board_pkg::BDST_W-1:0]  bdst,
   // video refresh read port
   input  logic                          vga_req,
   input  logic [mem_pkg::VRAM_AW-1:0]   vga_addr,
   output logic [mem_pkg::DATA_W-1:0]    vga_rdata,
   output logic                          vga_ready,
   output logic                          vga_done,
   // cpu main memory port
   input  logic                          sdram_req,
   input  logic                          sdram_write,
   input  logic [mem_pkg::SDRAM_AW-1:0]  sdram_addr,
   input  logic [mem_pkg::DATA_W-1:0]    sdram_wdata,
   output logic [mem_pkg::DATA_W-1:0]    sdram_rdata,
   output logic                          sdram_ready,
   output logic                          sdram_done,
   // cpu video memory port
   input  logic                          vram_req,
   input  logic                          vram_write,
   input  logic [mem_pkg::VRAM_AW-1:0]   vram_addr,
   input  logic [mem_pkg::DATA_W-1:0]    vram_wdata,
   output logic [mem_pkg::DATA_W-1:0]    vram_rdata,
   output logic                          vram_ready,
   output logic                          vram_done,
   // to the core
   output logic                          machine_reset,
   output logic                          boot,
   output logic                          cpu_en,
   output logic [15:0]                   led
);
   import board_pkg::*;
   import mem_pkg::*;

   logic        dram_reset;
   rst_state_t  rst_st;
   logic [2:0]  cpu_st;

   mem_port_if port_vga ();
   mem_port_if port_sdram ();
   mem_port_if port_vram ();
   dram_cmd_if cmd_bus ();

   //////////////////////////////
   // ports into interfaces
   //////////////////////////////
   always_comb begin
      port_vga.addr              = '0;    // pad bits zero
      port_vga.addr.video.region = REGION_VIDEO;
      port_vga.addr.video.addr   = vga_addr;
      port_sdram.addr.main.region = REGION_MAIN;
      port_sdram.addr.main.addr   = sdram_addr;
      port_vram.addr              = '0;
      port_vram.addr.video.region = REGION_VIDEO;
      port_vram.addr.video.addr   = vram_addr;
   end

   assign port_vga.req     = vga_req;
   assign port_vga.write   = 1'b0;        // refresh never writes
   assign port_vga.wdata   = '0;
   assign port_sdram.req   = sdram_req;
   assign port_sdram.write = sdram_write;
   assign port_sdram.wdata = sdram_wdata;
   assign port_vram.req    = vram_req;
   assign port_vram.write  = vram_write;
   assign port_vram.wdata  = vram_wdata;

   assign vga_rdata   = port_vga.rdata;
   assign vga_ready   = port_vga.ready;
   assign vga_done    = port_vga.done;
   assign sdram_rdata = port_sdram.rdata;
   assign sdram_ready = port_sdram.ready;
   assign sdram_done  = port_sdram.done;
   assign vram_rdata  = port_vram.rdata;
   assign vram_ready  = port_vram.ready;
   assign vram_done   = port_vram.done;

   reset_sequencer i_reset_sequencer (
      .sysclk        (sysclk),
      .rst           (rst),
      .calib_done    (cmd_bus.calib_done),
      .dram_reset    (dram_reset),
      .machine_reset (machine_reset),
      .boot          (boot),
      .cpu_en        (cpu_en),
      .rst_st        (rst_st),
      .cpu_st        (cpu_st)
   );

   mem_arbiter i_mem_arbiter (
      .sysclk (sysclk),
      .rst    (rst),
      .vga    (port_vga.server),
      .sdram  (port_sdram.server),
      .vram   (port_vram.server),
      .cmd    (cmd_bus.master)
   );

   dram_backend i_dram_backend (
      .sysclk     (sysclk),
      .dram_reset (dram_reset),
      .cmd        (cmd_bus.slave)
   );

   status_leds i_status_leds (
      .sysclk     (sysclk),
      .rst        (rst),
      .calib_done (cmd_bus.calib_done),
      .boot       (boot),
      .promdis    (promdis),
      .cpu_st     (cpu_st),
      .rst_st     (rst_st),
      .bdst       (bdst),
      .led        (led)
   );

endmodule

`default_nettype wire

//--- src/status_leds.sv
// flags are sticky until rst; dimmed leds stay dark for the first half dimmer period
`timescale 1ns/1ns
`default_nettype none

module status_leds (
   input  logic                          sysclk,
   input  logic                          rst,
   input  logic                          calib_done,
   input  logic                          boot,
   input  logic                          promdis,
   input  logic [2:0]                    cpu_st,
   input  board_pkg::rst_state_t         rst_st,
   input  logic [board_pkg::BDST_W-1:0]  bdst,
   output logic [15:0]                   led
);
   import board_pkg::*;

   logic                    calib_seen;
   logic                    boot_seen;
   logic                    promdis_seen;
   logic [DIMMER_BITS-1:0]  dimmer;
   logic                    dim_en;   // registered top bit of dimmer
   logic [2:0]              rs_bits;

   always_ff @(posedge sysclk) begin
      if (rst) begin
         calib_seen   <= 1'b0;
         boot_seen    <= 1'b0;
         promdis_seen <= 1'b0;
         dimmer       <= '0;
         dim_en       <= 1'b0;
      end else begin
         calib_seen   <= calib_seen | calib_done;
         boot_seen    <= boot_seen | boot;
         promdis_seen <= promdis_seen | promdis;
         dimmer       <= dimmer + 1'b1;
         dim_en       <= dimmer[DIMMER_BITS-1];
      end
   end

   assign rs_bits = rst_st;

   always_comb begin
      led[0]  = calib_seen;             // full brightness
      led[1]  = cpu_st[0];
      led[2]  = cpu_st[1];
      led[3]  = cpu_st[2];
      // rgb groups, dimmed
      led[4]  = rs_bits[0] & dim_en;
      led[5]  = promdis_seen & dim_en;
      led[6]  = bdst[0] & dim_en;
      led[7]  = rs_bits[1] & dim_en;
      led[8]  = bdst[1] & dim_en;
      led[9]  = bdst[2] & dim_en;
      led[10] = rs_bits[2] & dim_en;
      led[11] = bdst[3] & dim_en;
      led[12] = bdst[4] & dim_en;
      led[13] = boot_seen & dim_en;
      led[14] = bdst[5] & dim_en;
      led[15] = bdst[6] & dim_en;
   end

endmodule

`default_nettype wire

//--- src/dram_backend.sv
// behavioural memory, 1024 words per region, contents undefined until written
`timescale 1ns/1ns
`default_nettype none

module dram_backend (
   input  logic       sysclk,
   input  logic       dram_reset,
   dram_cmd_if.slave  cmd
);
   import mem_pkg::*;

   logic [DATA_W-1:0]      mem_array [2**(STORE_AW+1)];
   logic [STORE_AW:0]      idx;       // {region, low address bits}
   logic [CALIB_CNT_W-1:0] calib_cnt;
   logic                   calib_q;
   logic [MEM_LATENCY-1:0] vld_pipe;
   client_t                tag_pipe  [MEM_LATENCY];
   logic [DATA_W-1:0]      data_pipe [MEM_LATENCY];

   // calibration delay after reset release
   always_ff @(posedge sysclk) begin
      if (dram_reset) begin
         calib_cnt <= '0;
         calib_q   <= 1'b0;
      end else if (!calib_q) begin
         calib_cnt <= calib_cnt + 1'b1;
         if (calib_cnt == CALIB_CNT_W'(CALIB_CYCLES - 1))
            calib_q <= 1'b1;
      end
   end

   // region bit first, then low bits from that region's view
   always_comb begin
      if (cmd.addr.main.region == REGION_VIDEO)
         idx = {1'b1, cmd.addr.video.addr[STORE_AW-1:0]};
      else
         idx = {1'b0, cmd.addr.main.addr[STORE_AW-1:0]};
   end

   always_ff @(posedge sysclk) begin
      if (dram_reset)
         vld_pipe <= '0;
      else
         vld_pipe <= {vld_pipe[MEM_LATENCY-2:0], cmd.issue};
   end

   always_ff @(posedge sysclk) begin
      tag_pipe[0]  <= cmd.tag;
      data_pipe[0] <= mem_array[idx]; // read at issue, old data on a write
      for (int i = 1; i < MEM_LATENCY; i++) begin
         tag_pipe[i]  <= tag_pipe[i-1];
         data_pipe[i] <= data_pipe[i-1];
      end
      if (cmd.issue && cmd.write)
         mem_array[idx] <= cmd.wdata; // seen by any later issue
   end

   assign cmd.calib_done = calib_q;
   assign cmd.res_valid  = vld_pipe[MEM_LATENCY-1];
   assign cmd.res_tag    = tag_pipe[MEM_LATENCY-1];
   assign cmd.rdata      = data_pipe[MEM_LATENCY-1];

endmodule

`default_nettype wire

//--- src/mem_arbiter.sv
// fixed priority vga > sdram > vram; one issue per cycle, each client one request at a time
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
   input  logic        sysclk,
   input  logic        rst,
   mem_port_if.server  vga,
   mem_port_if.server  sdram,
   mem_port_if.server  vram,
   dram_cmd_if.master  cmd
);
   import mem_pkg::*;

   // per client, indexed by tag value
   logic [NUM_CLIENTS-1:0]  req_in;
   logic [NUM_CLIENTS-1:0]  wr_in;
   mem_addr_u               addr_in  [NUM_CLIENTS];
   logic [DATA_W-1:0]       wdata_in [NUM_CLIENTS];
   logic [NUM_CLIENTS-1:0]  ready;
   logic [NUM_CLIENTS-1:0]  done;

   logic [NUM_CLIENTS-1:0]  pend_q;   // latched, not yet issued
   logic [NUM_CLIENTS-1:0]  flight_q; // issued, result pending
   logic [NUM_CLIENTS-1:0]  wr_q;
   mem_addr_u               addr_q   [NUM_CLIENTS];
   logic [DATA_W-1:0]       wdata_q  [NUM_CLIENTS];
   client_t                 sel;

   //////////////////////////////
   // gather ports
   //////////////////////////////
   assign req_in = {vram.req, sdram.req, vga.req};
   assign wr_in  = {vram.write, sdram.write, vga.write};
   assign addr_in[TAG_VGA]    = vga.addr;
   assign addr_in[TAG_SDRAM]  = sdram.addr;
   assign addr_in[TAG_VRAM]   = vram.addr;
   assign wdata_in[TAG_VGA]   = vga.wdata;
   assign wdata_in[TAG_SDRAM] = sdram.wdata;
   assign wdata_in[TAG_VRAM]  = vram.wdata;

   assign ready = {NUM_CLIENTS{cmd.calib_done}} & ~(pend_q | flight_q);

   always_ff @(posedge sysclk) begin
      if (rst) begin
         pend_q   <= '0;
         flight_q <= '0;
      end else begin
         for (int i = 0; i < NUM_CLIENTS; i++) begin
            if (req_in[i] && ready[i])
               pend_q[i] <= 1'b1;
         end
         if (cmd.issue) begin
            pend_q[sel]   <= 1'b0;
            flight_q[sel] <= 1'b1;
         end
         if (cmd.res_valid)
            flight_q[cmd.res_tag] <= 1'b0; // slot free, ready next cycle
      end
   end

   // request payload, held until issue
   always_ff @(posedge sysclk) begin
      for (int i = 0; i < NUM_CLIENTS; i++) begin
         if (req_in[i] && ready[i]) begin
            wr_q[i]    <= wr_in[i];
            addr_q[i]  <= addr_in[i];
            wdata_q[i] <= wdata_in[i];
         end
      end
   end

   always_comb begin
      sel = TAG_VGA;
      if (pend_q[TAG_VGA])        sel = TAG_VGA;
      else if (pend_q[TAG_SDRAM]) sel = TAG_SDRAM;
      else if (pend_q[TAG_VRAM])  sel = TAG_VRAM;
   end

   assign cmd.issue = |pend_q;
   assign cmd.tag   = sel;
   assign cmd.write = wr_q[sel];
   assign cmd.addr  = addr_q[sel];
   assign cmd.wdata = wdata_q[sel];

   //////////////////////////////
   // results back to clients
   //////////////////////////////
   assign done[TAG_VGA]   = cmd.res_valid && (cmd.res_tag == TAG_VGA);
   assign done[TAG_SDRAM] = cmd.res_valid && (cmd.res_tag == TAG_SDRAM);
   assign done[TAG_VRAM]  = cmd.res_valid && (cmd.res_tag == TAG_VRAM);

   assign vga.ready   = ready[TAG_VGA];
   assign sdram.ready = ready[TAG_SDRAM];
   assign vram.ready  = ready[TAG_VRAM];
   assign vga.done    = done[TAG_VGA];
   assign sdram.done  = done[TAG_SDRAM];
   assign vram.done   = done[TAG_VRAM];
   assign vga.rdata   = done[TAG_VGA]   ? cmd.rdata : '0;
   assign sdram.rdata = done[TAG_SDRAM] ? cmd.rdata : '0;
   assign vram.rdata  = done[TAG_VRAM]  ? cmd.rdata : '0;

endmodule

`default_nettype wire

//--- src/reset_sequencer.sv
// waits on calib_done with no timeout; cpu_en is a clock enable on sysclk, not a clock
`timescale 1ns/1ns
`default_nettype none

module reset_sequencer (
   input  logic                  sysclk,
   input  logic                  rst,
   input  logic                  calib_done,
   output logic                  dram_reset,
   output logic                  machine_reset,
   output logic                  boot,
   output logic                  cpu_en,
   output board_pkg::rst_state_t rst_st,
   output logic [2:0]            cpu_st
);
   import board_pkg::*;

   rst_state_t             state;
   logic [SEQ_CNT_W-1:0]   cnt;       // shared by both timed states
   logic                   boot_seen; // sticky, one cycle behind boot

   always_ff @(posedge sysclk) begin
      if (rst) begin
         state         <= RS_DRAM_RESET;
         cnt           <= '0;
         dram_reset    <= 1'b1;
         machine_reset <= 1'b1;
         boot          <= 1'b0;
         cpu_en        <= 1'b0;
         boot_seen     <= 1'b0;
      end else begin
         boot      <= 1'b0;               // pulse by default
         boot_seen <= boot_seen | boot;
         case (state)
            RS_DRAM_RESET: begin
               cnt <= cnt + 1'b1;
               if (cnt == SEQ_CNT_W'(DRAM_RESET_CYCLES - 1)) begin
                  state      <= RS_CALIB;
                  dram_reset <= 1'b0;     // back end starts calibrating
                  cnt        <= '0;
               end
            end
            RS_CALIB: begin
               if (calib_done)
                  state <= RS_MACH_RESET;
            end
            RS_MACH_RESET: begin
               cnt <= cnt + 1'b1;
               if (cnt == SEQ_CNT_W'(MACH_RESET_CYCLES - 1)) begin
                  state         <= RS_RUN;
                  machine_reset <= 1'b0;
                  boot          <= 1'b1;  // same edge as machine_reset fall
                  cnt           <= '0;
               end
            end
            RS_RUN: begin
               cpu_en <= ~cpu_en;         // half-rate cpu step
            end
            default: begin
               state <= RS_DRAM_RESET;
            end
         endcase
      end
   end

   assign rst_st = state;

   // {running, boot seen, machine reset}
   assign cpu_st = {state == RS_RUN, boot_seen, machine_reset};

endmodule

`default_nettype wire

//--- src/dram_cmd_if.sv
// arbiter to back end bus; no back-pressure, every issue is taken in its cycle
`timescale 1ns/1ns
`default_nettype none

interface dram_cmd_if;
   import mem_pkg::*;

   logic                issue;
   logic                write;
   mem_addr_u           addr;
   logic [DATA_W-1:0]   wdata;
   client_t             tag;       // follows the request through the pipe
   logic                res_valid;
   client_t             res_tag;
   logic [DATA_W-1:0]   rdata;
   logic                calib_done;

   modport master (
      output issue, write, addr, wdata, tag,
      input  res_valid, res_tag, rdata, calib_done
   );

   modport slave (
      input  issue, write, addr, wdata, tag,
      output res_valid, res_tag, rdata, calib_done
   );

endinterface

`default_nettype wire

//--- src/mem_port_if.sv
// one client port; req only while ready, at most one request outstanding per client
`timescale 1ns/1ns
`default_nettype none

interface mem_port_if;
   import mem_pkg::*;

   logic                req;   // one-cycle strobe
   logic                write;
   mem_addr_u           addr;
   logic [DATA_W-1:0]   wdata;
   logic [DATA_W-1:0]   rdata; // valid with done
   logic                ready; // level, low while busy
   logic                done;  // one-cycle strobe

   modport client (
      output req, write, addr, wdata,
      input  rdata, ready, done
   );

   modport server (
      input  req, write, addr, wdata,
      output rdata, ready, done
   );

endinterface

`default_nettype wire

//--- src/mem_pkg.sv
// memory map and timing; only STORE_AW low bits per region are kept, higher bits alias
`default_nettype none

package mem_pkg;

   localparam int DATA_W      = 32;
   localparam int SDRAM_AW    = 22; // cpu main memory word address
   localparam int VRAM_AW     = 15; // video memory word address
   localparam int STORE_AW    = 10; // bits kept per region in the back end
   localparam int MEM_LATENCY = 3;  // issue to result
   localparam int NUM_CLIENTS = 3;

   // back end calibration model
   localparam int CALIB_CYCLES = 32;
   localparam int CALIB_CNT_W  = 6;

   typedef enum logic {
      REGION_MAIN  = 1'b0,
      REGION_VIDEO = 1'b1
   } region_t;

   // tag value doubles as the client slot index and its priority (low wins)
   typedef enum logic [1:0] {
      TAG_VGA   = 2'd0,
      TAG_SDRAM = 2'd1,
      TAG_VRAM  = 2'd2
   } client_t;

   // same 23-bit word, read as main or video address
   typedef union packed {
      struct packed {
         region_t               region;
         logic [SDRAM_AW-1:0]   addr;
      } main;
      struct packed {
         region_t                      region; // same bit as main.region
         logic [SDRAM_AW-VRAM_AW-1:0]  pad;
         logic [VRAM_AW-1:0]           addr;
      } video;
   } mem_addr_u;

endpackage

`default_nettype wire

//--- src/board_pkg.sv
// reset sequencing and LED constants; lengths assume the single sysclk domain
`default_nettype none

package board_pkg;

   //////////////////////////////
   // reset sequencer
   //////////////////////////////

   // 3 bits so the state can go straight out as rst_st
   typedef enum logic [2:0] {
      RS_DRAM_RESET = 3'b001, // dram held in reset
      RS_CALIB      = 3'b010, // waiting on calibration
      RS_MACH_RESET = 3'b011, // machine reset after calib
      RS_RUN        = 3'b100  // boot done, cpu_en toggling
   } rst_state_t;

   localparam int DRAM_RESET_CYCLES = 16;
   localparam int MACH_RESET_CYCLES = 8;
   localparam int SEQ_CNT_W         = $clog2(DRAM_RESET_CYCLES) + 1; // covers both lengths

   //////////////////////////////
   // status leds
   //////////////////////////////

   localparam int DIMMER_BITS = 20; // top bit gives about 50% duty
   localparam int BDST_W      = 7;  // boot disk status bits shown

endpackage

`default_nettype wire
